//--- frame_buf.f
+incdir+rtl
rtl/frame_buf_pkg.sv
rtl/sdram_req_if.sv
rtl/sync_fifo.sv
rtl/page_arbiter.sv
rtl/sdram_cmd_engine.sv
rtl/frame_buf_top.sv
testbench/sdram_model.sv
testbench/frame_buf_chk.sv
testbench/frame_buf_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the frame buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f frame_buf.f \
    --top-module frame_buf_tb -o frame_buf_sim

./obj_dir/frame_buf_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi

//--- testbench/frame_buf_tb.sv
`timescale 1ns/10ps
`include "frame_buf_config.svh"

module frame_buf_tb
    import frame_buf_pkg::*;
();
    localparam int FRAME_WORDS = `FB_FRAME_PAGES * `FB_PAGE_LEN;
    localparam int NUM_TESTS   = 5;
    localparam int TIMEOUT_NS  = NUM_TESTS * FRAME_WORDS * 200;

    logic                  s_sdram_clk;
    logic                  s_sdram_rst;
    logic                  i_pix_valid;
    pixel_t                i_pix_data;
    logic                  o_pix_ready;
    logic                  o_rd_valid;
    pixel_t                o_rd_data;
    logic                  o_rd_sof;
    logic                  i_rd_ready;
    logic                  i_new_frame;
    logic                  cke;
    logic                  cs_n;
    logic                  ras_n;
    logic                  cas_n;
    logic                  we_n;
    logic [`FB_ROW_W-1:0]  addr;
    logic [`FB_BANK_W-1:0] ba;
    logic [1:0]            dqm;
    pixel_t                dq_out;
    logic                  dq_oe;
    pixel_t                dq_in;
    logic                  o_init_done;
    int                    model_errors;
    int                    write_bursts;

    pixel_t frame_pix [FRAME_WORDS];
    int     errors;
    int     checks;
    int     test_errors;

    frame_buf_top frame_buf_i (
        .s_sdram_clk (s_sdram_clk), .s_sdram_rst (s_sdram_rst),
        .i_pix_valid (i_pix_valid), .i_pix_data (i_pix_data), .o_pix_ready (o_pix_ready),
        .o_rd_valid (o_rd_valid), .o_rd_data (o_rd_data), .o_rd_sof (o_rd_sof),
        .i_rd_ready (i_rd_ready), .i_new_frame (i_new_frame),
        .o_sdram_cke (cke), .o_sdram_cs_n (cs_n), .o_sdram_ras_n (ras_n),
        .o_sdram_cas_n (cas_n), .o_sdram_we_n (we_n), .o_sdram_addr (addr),
        .o_sdram_ba (ba), .o_sdram_dqm (dqm), .o_sdram_dq (dq_out),
        .o_sdram_dq_oe (dq_oe), .i_sdram_dq (dq_in), .o_init_done (o_init_done)
    );

    sdram_model model_i (
        .s_sdram_clk (s_sdram_clk), .s_sdram_rst (s_sdram_rst), .i_cke (cke),
        .i_cs_n (cs_n), .i_ras_n (ras_n), .i_cas_n (cas_n), .i_we_n (we_n),
        .i_addr (addr), .i_ba (ba), .i_dqm (dqm), .i_dq (dq_out), .i_dq_oe (dq_oe),
        .o_dq (dq_in), .o_errors (model_errors), .o_write_bursts (write_bursts)
    );

    bind frame_buf_top frame_buf_chk chk_i (
        .s_sdram_clk (s_sdram_clk), .s_sdram_rst (s_sdram_rst),
        .i_rw_en (req_if.rw_en), .i_rw (req_if.rw), .i_ready (req_if.ready),
        .i_dq_oe (o_sdram_dq_oe), .i_cke (o_sdram_cke)
    );

    always #4 s_sdram_clk = ~s_sdram_clk;

    // watchdog sized from test count and frame length
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic compare_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    // init done must show up, nothing to read before it
    task automatic wait_init();
        int cycles;
        cycles = 0;
        while (!o_init_done && cycles < 200) begin
            @(negedge s_sdram_clk);
            compare_val("o_rd_valid", 32'(o_rd_valid), 0);
            // empty write fifo accepts pixels
            compare_val("o_pix_ready", 32'(o_pix_ready), 1);
            cycles++;
        end
        if (!o_init_done) begin
            errors++;
            $display("o_init_done never rose after reset");
        end
    endtask

    task automatic fill_frame();
        for (int i = 0; i < FRAME_WORDS; i++) begin
            frame_pix[i] = pixel_t'($urandom);
        end
    endtask

    task automatic write_frame();
        logic accepted;
        @(posedge s_sdram_clk);
        #1;
        for (int i = 0; i < FRAME_WORDS; i++) begin
            i_pix_valid = 1'b1;
            i_pix_data  = frame_pix[i];
            do begin
                @(negedge s_sdram_clk);
                accepted = o_pix_ready;
                @(posedge s_sdram_clk);
                #1;
            end while (!accepted);
        end
        i_pix_valid = 1'b0;
    endtask

    // count WRITE commands on the pins until the frame is stored
    task automatic wait_write_bursts(input int target);
        int cycles;
        cycles = 0;
        while (write_bursts < target && cycles < 400) begin
            @(negedge s_sdram_clk);
            cycles++;
        end
        if (write_bursts < target) begin
            errors++;
            $display("only %0d write bursts reached the sdram, %0d expected", write_bursts, target);
        end
    endtask

    task automatic pulse_new_frame();
        @(posedge s_sdram_clk);
        #1;
        i_new_frame = 1'b1;
        @(posedge s_sdram_clk);
        #1;
        i_new_frame = 1'b0;
    endtask

    // leftover words before the sof word are skipped
    task automatic read_frame(input bit stall, input int count);
        int got;
        int cycles;
        bit synced;
        got    = 0;
        cycles = 0;
        synced = 1'b0;
        while (got < count && cycles < 20 * count + 200) begin
            @(posedge s_sdram_clk);
            #1;
            i_rd_ready = stall ? 1'($urandom % 2) : 1'b1;
            cycles++;
            @(negedge s_sdram_clk);
            if (o_rd_valid && i_rd_ready) begin
                if (o_rd_sof) begin
                    synced = 1'b1;
                end
                if (synced) begin
                    compare_val("o_rd_data", 32'(o_rd_data), 32'(frame_pix[got]));
                    compare_val("o_rd_sof", 32'(o_rd_sof), 32'(got == 0));
                    got++;
                end
            end
        end
        @(posedge s_sdram_clk);
        #1;
        i_rd_ready = 1'b0;
        if (got < count) begin
            errors++;
            $display("read-out stalled with %0d of %0d words received", got, count);
        end
    endtask

    initial begin
        void'($urandom(28846));
        s_sdram_clk = 1'b0;
        s_sdram_rst = 1'b1;
        i_pix_valid = 1'b0;
        i_pix_data  = '0;
        i_rd_ready  = 1'b0;
        i_new_frame = 1'b0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        repeat (2) @(posedge s_sdram_clk);
        #1;
        s_sdram_rst = 1'b0;

        wait_init();
        end_test("init");

        fill_frame();
        write_frame();
        wait_write_bursts(`FB_FRAME_PAGES);
        pulse_new_frame();
        read_frame(1'b0, FRAME_WORDS);
        end_test("replay");

        pulse_new_frame();
        read_frame(1'b1, FRAME_WORDS);
        end_test("replay_stall");

        // restart partway through a replay
        pulse_new_frame();
        read_frame(1'b0, 12);
        pulse_new_frame();
        read_frame(1'b1, FRAME_WORDS);
        end_test("restart");

        // second frame lands on rows 0 upward again
        fill_frame();
        write_frame();
        wait_write_bursts(2 * `FB_FRAME_PAGES);
        pulse_new_frame();
        read_frame(1'b0, FRAME_WORDS);
        end_test("second_frame");

        errors += model_errors;
        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/frame_buf_chk.sv
`timescale 1ns/10ps

module frame_buf_chk (
    input logic s_sdram_clk,
    input logic s_sdram_rst,
    input logic i_rw_en,
    input logic i_rw,
    input logic i_ready,
    input logic i_dq_oe,
    input logic i_cke
);
    // request strobe only toward an idle engine
    rw_en_needs_ready: assert property (@(posedge s_sdram_clk) disable iff (s_sdram_rst)
        i_rw_en |-> i_ready)
        else $error("rw_en raised while the engine was busy");

    // dq driven only inside a write burst
    dq_oe_in_write: assert property (@(posedge s_sdram_clk) disable iff (s_sdram_rst)
        i_dq_oe |-> (!i_ready && !i_rw))
        else $error("dq output enable outside a write burst");

    cke_high: assert property (@(posedge s_sdram_clk) disable iff (s_sdram_rst)
        i_cke)
        else $error("cke low after reset");

endmodule

//--- testbench/sdram_model.sv
`timescale 1ns/10ps
`include "frame_buf_config.svh"

module sdram_model
    import frame_buf_pkg::*;
(
    input  logic                  s_sdram_clk,
    input  logic                  s_sdram_rst,
    input  logic                  i_cke,
    input  logic                  i_cs_n,
    input  logic                  i_ras_n,
    input  logic                  i_cas_n,
    input  logic                  i_we_n,
    input  logic [`FB_ROW_W-1:0]  i_addr,
    input  logic [`FB_BANK_W-1:0] i_ba,
    input  logic [1:0]            i_dqm,
    input  pixel_t                i_dq,
    input  logic                  i_dq_oe,
    output pixel_t                o_dq,
    output int                    o_errors,
    output int                    o_write_bursts
);
    // 32 rows of one page each, enough for the frame
    pixel_t     mem [256];
    sdram_cmd_e cmd;
    bit         mode_loaded;
    int         open_row;
    int         act_age;
    int         wr_left;
    int         wr_col;
    int         rd_wait;
    int         rd_left;
    int         rd_col;

    // device ignores commands while cke is low
    assign cmd = i_cke ? sdram_cmd_e'({i_cs_n, i_ras_n, i_cas_n, i_we_n}) : CMD_NOP;

    initial o_dq = '0;
    initial o_errors = 0;
    initial o_write_bursts = 0;

    always @(posedge s_sdram_clk) begin
        if (s_sdram_rst) begin
            mode_loaded = 1'b0;
            act_age     = 100;
            wr_left     = 0;
            rd_left     = 0;
            o_dq       <= '0;
        end else begin
            // row commands only once the mode register holds a value
            if (!mode_loaded && (cmd == CMD_ACTIVE || cmd == CMD_READ || cmd == CMD_WRITE)) begin
                $display("sdram model: access command issued before initialisation at %0t", $time);
                o_errors++;
            end
            if ((cmd == CMD_READ || cmd == CMD_WRITE) && act_age + 1 < `FB_TRCD) begin
                $display("sdram model: read or write came too soon after active at %0t", $time);
                o_errors++;
            end
            // only bank 0 is modelled
            if ((cmd == CMD_ACTIVE || cmd == CMD_READ || cmd == CMD_WRITE) && i_ba != '0) begin
                $display("sdram model: bank %0d addressed instead of bank 0 at %0t",
                         i_ba, $time);
                o_errors++;
            end
            case (cmd)
                CMD_LOAD_MODE: mode_loaded = 1'b1;
                CMD_ACTIVE: begin
                    open_row = int'(i_addr) % 32;
                    act_age  = 0;
                end
                CMD_WRITE: begin
                    wr_left = `FB_PAGE_LEN;
                    wr_col  = 0;
                    o_write_bursts++;
                end
                CMD_READ: begin
                    // data goes out so the DUT samples it CL edges later
                    rd_wait = `FB_CAS_LAT - 2;
                    rd_left = `FB_PAGE_LEN;
                    rd_col  = 0;
                end
                default: ;
            endcase
            // write words arrive together with the command
            if (wr_left > 0) begin
                if (i_dq_oe && i_dqm == 2'b00) begin
                    mem[open_row * `FB_PAGE_LEN + wr_col] = i_dq;
                end
                wr_col++;
                wr_left--;
            end
            if (cmd != CMD_READ && rd_left > 0) begin
                if (rd_wait > 0) begin
                    rd_wait--;
                end else begin
                    o_dq <= mem[open_row * `FB_PAGE_LEN + rd_col];
                    rd_col++;
                    rd_left--;
                end
            end
            if (cmd != CMD_ACTIVE && act_age < 100) begin
                act_age++;
            end
        end
    end

endmodule

//--- rtl/frame_buf_top.sv
`timescale 1ns/10ps
`include "frame_buf_config.svh"

module frame_buf_top
    import frame_buf_pkg::*;
(
    input  logic                  s_sdram_clk,
    input  logic                  s_sdram_rst,
    input  logic                  i_pix_valid,
    input  logic [`FB_DATA_W-1:0] i_pix_data,
    output logic                  o_pix_ready,
    output logic                  o_rd_valid,
    output logic [`FB_DATA_W-1:0] o_rd_data,
    output logic                  o_rd_sof,
    input  logic                  i_rd_ready,
    input  logic                  i_new_frame,
    output logic                  o_sdram_cke,
    output logic                  o_sdram_cs_n,
    output logic                  o_sdram_ras_n,
    output logic                  o_sdram_cas_n,
    output logic                  o_sdram_we_n,
    output logic [`FB_ROW_W-1:0]  o_sdram_addr,
    output logic [`FB_BANK_W-1:0] o_sdram_ba,
    output logic [1:0]            o_sdram_dqm,
    output logic [`FB_DATA_W-1:0] o_sdram_dq,
    output logic                  o_sdram_dq_oe,
    input  logic [`FB_DATA_W-1:0] i_sdram_dq,
    output logic                  o_init_done
);
    // two pages of slack on each side
    localparam int FIFO_DEPTH = 2 * `FB_PAGE_LEN;
    localparam int CNT_W      = $clog2(FIFO_DEPTH) + 1;

    sdram_req_if req_if ();

    pixel_t           wr_data;
    logic             wr_valid;
    logic             wr_pop;
    logic [CNT_W-1:0] wr_count;
    logic [CNT_W-1:0] rd_count;
    logic             rd_flush;
    logic             rd_push;
    rd_word_t         rd_word_in;
    rd_word_t         rd_word_out;

    assign o_rd_data = rd_word_out.pix;
    assign o_rd_sof  = rd_word_out.sof;

    // pixels waiting for a write burst
    sync_fifo #(
        .payload_t (pixel_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_wr_fifo (
        .s_sdram_clk (s_sdram_clk),
        .s_sdram_rst (s_sdram_rst),
        .i_flush     (1'b0),
        .i_wr_valid  (i_pix_valid),
        .i_wr_data   (i_pix_data),
        .o_wr_ready  (o_pix_ready),
        .o_rd_valid  (wr_valid),
        .o_rd_data   (wr_data),
        .i_rd_ready  (wr_pop),
        .o_count     (wr_count)
    );

    // replayed words, room reserved by the arbiter
    sync_fifo #(
        .payload_t (rd_word_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_rd_fifo (
        .s_sdram_clk (s_sdram_clk),
        .s_sdram_rst (s_sdram_rst),
        .i_flush     (rd_flush),
        .i_wr_valid  (rd_push),
        .i_wr_data   (rd_word_in),
        .o_wr_ready  (),
        .o_rd_valid  (o_rd_valid),
        .o_rd_data   (rd_word_out),
        .i_rd_ready  (i_rd_ready),
        .o_count     (rd_count)
    );

    page_arbiter #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_arbiter (
        .s_sdram_clk (s_sdram_clk),
        .s_sdram_rst (s_sdram_rst),
        .i_new_frame (i_new_frame),
        .i_wr_count  (wr_count),
        .i_rd_count  (rd_count),
        .o_rd_flush  (rd_flush),
        .req         (req_if.arb)
    );

    sdram_cmd_engine u_engine (
        .s_sdram_clk   (s_sdram_clk),
        .s_sdram_rst   (s_sdram_rst),
        .req           (req_if.eng),
        .i_wr_data     (wr_data),
        .i_wr_valid    (wr_valid),
        .o_wr_pop      (wr_pop),
        .o_rd_push     (rd_push),
        .o_rd_word     (rd_word_in),
        .o_sdram_cke   (o_sdram_cke),
        .o_sdram_cs_n  (o_sdram_cs_n),
        .o_sdram_ras_n (o_sdram_ras_n),
        .o_sdram_cas_n (o_sdram_cas_n),
        .o_sdram_we_n  (o_sdram_we_n),
        .o_sdram_addr  (o_sdram_addr),
        .o_sdram_ba    (o_sdram_ba),
        .o_sdram_dqm   (o_sdram_dqm),
        .o_sdram_dq    (o_sdram_dq),
        .o_sdram_dq_oe (o_sdram_dq_oe),
        .i_sdram_dq    (i_sdram_dq),
        .o_init_done   (o_init_done)
    );

endmodule

//--- rtl/sdram_cmd_engine.sv
`timescale 1ns/10ps
`include "frame_buf_config.svh"

module sdram_cmd_engine
    import frame_buf_pkg::*;
(
    input  logic                  s_sdram_clk,
    input  logic                  s_sdram_rst,
    sdram_req_if.eng              req,
    input  pixel_t                i_wr_data,
    input  logic                  i_wr_valid,
    output logic                  o_wr_pop,
    output logic                  o_rd_push,
    output rd_word_t              o_rd_word,
    output logic                  o_sdram_cke,
    output logic                  o_sdram_cs_n,
    output logic                  o_sdram_ras_n,
    output logic                  o_sdram_cas_n,
    output logic                  o_sdram_we_n,
    output logic [`FB_ROW_W-1:0]  o_sdram_addr,
    output logic [`FB_BANK_W-1:0] o_sdram_ba,
    output logic [1:0]            o_sdram_dqm,
    output pixel_t                o_sdram_dq,
    output logic                  o_sdram_dq_oe,
    input  pixel_t                i_sdram_dq,
    output logic                  o_init_done
);
    localparam int ROW_W = `FB_ROW_W;
    localparam int CL    = `FB_CAS_LAT;
    // auto refresh and mode register recovery
    localparam int T_RFC = 7;
    localparam int T_MRD = 2;
    localparam int CNT_W = $clog2(`FB_INIT_WAIT + `FB_PAGE_LEN + CL + T_RFC);

    // read window covers the cas latency tail
    localparam logic [CNT_W-1:0] RD_LAST = CNT_W'(`FB_PAGE_LEN + CL - 1);
    localparam logic [CNT_W-1:0] RD_TAIL = CNT_W'(CL);
    // write gets one spare cycle before precharge
    localparam logic [CNT_W-1:0] WR_LAST = CNT_W'(`FB_PAGE_LEN);
    localparam logic [CNT_W-1:0] WR_TAIL = CNT_W'(1);
    // A10 high selects all banks
    localparam logic [ROW_W-1:0] PRE_ALL = ROW_W'(1 << 10);
    // sequential burst, write burst on, cas and length from config
    localparam logic [ROW_W-1:0] MODE_WORD =
        ROW_W'({3'(CL), 1'b0, 3'($clog2(`FB_PAGE_LEN))});

    typedef enum logic [3:0] {
        ST_INIT_WAIT,
        ST_INIT_PRE,
        ST_INIT_REF1,
        ST_INIT_REF2,
        ST_INIT_MODE,
        ST_IDLE,
        ST_TRCD,
        ST_DATA,
        ST_TRP
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;
    sdram_cmd_e       cmd_q;
    logic             rw_q;
    logic             sof_pend;
    logic             burst_rd;
    logic [CL-1:0]    rd_pipe;
    logic [CNT_W-1:0] burst_last;
    logic [CNT_W-1:0] burst_tail;
    logic             data_beat;

    assign {o_sdram_cs_n, o_sdram_ras_n, o_sdram_cas_n, o_sdram_we_n} = cmd_q;
    // clock never suspended, no power-down
    assign o_sdram_cke = 1'b1;
    // whole frame lives in bank 0
    assign o_sdram_ba  = '0;

    assign req.ready = (state == ST_IDLE);

    // cnt counts down through the data window
    assign burst_last = rw_q ? RD_LAST : WR_LAST;
    assign burst_tail = rw_q ? RD_TAIL : WR_TAIL;
    assign data_beat  = (state == ST_DATA) && (cnt >= burst_tail);
    assign o_wr_pop   = data_beat && !rw_q && i_wr_valid;

    always_ff @(posedge s_sdram_clk) begin
        if (s_sdram_rst) begin
            state         <= ST_INIT_WAIT;
            cnt           <= CNT_W'(`FB_INIT_WAIT - 1);
            cmd_q         <= CMD_NOP;
            o_sdram_addr  <= '0;
            o_sdram_dqm   <= '0;
            o_sdram_dq_oe <= 1'b0;
            o_init_done   <= 1'b0;
            o_rd_push     <= 1'b0;
            rw_q          <= 1'b0;
            sof_pend      <= 1'b0;
            burst_rd      <= 1'b0;
            rd_pipe       <= '0;
        end else begin
            cmd_q         <= CMD_NOP;
            o_sdram_dqm   <= '0;
            o_sdram_dq_oe <= 1'b0;
            burst_rd      <= 1'b0;
            // marks cycles where dq holds read data
            rd_pipe       <= {rd_pipe[CL-2:0], burst_rd};
            o_rd_push     <= rd_pipe[CL-1];
            if (rd_pipe[CL-1]) begin
                sof_pend <= 1'b0;
            end
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
            case (state)
                ST_INIT_WAIT: if (cnt == '0) begin
                    cmd_q        <= CMD_PRECHARGE;
                    o_sdram_addr <= PRE_ALL;
                    state        <= ST_INIT_PRE;
                    cnt          <= CNT_W'(`FB_TRP - 1);
                end
                ST_INIT_PRE: if (cnt == '0) begin
                    cmd_q <= CMD_REFRESH;
                    state <= ST_INIT_REF1;
                    cnt   <= CNT_W'(T_RFC - 1);
                end
                ST_INIT_REF1: if (cnt == '0) begin
                    cmd_q <= CMD_REFRESH;
                    state <= ST_INIT_REF2;
                    cnt   <= CNT_W'(T_RFC - 1);
                end
                ST_INIT_REF2: if (cnt == '0) begin
                    cmd_q        <= CMD_LOAD_MODE;
                    o_sdram_addr <= MODE_WORD;
                    state        <= ST_INIT_MODE;
                    cnt          <= CNT_W'(T_MRD - 1);
                end
                ST_INIT_MODE: if (cnt == '0) begin
                    o_init_done <= 1'b1;
                    state       <= ST_IDLE;
                end
                ST_IDLE: if (req.rw_en) begin
                    cmd_q        <= CMD_ACTIVE;
                    o_sdram_addr <= req.row;
                    rw_q         <= req.rw;
                    sof_pend     <= req.rw && req.sof;
                    state        <= ST_TRCD;
                    // read or write goes out FB_TRCD after active
                    cnt          <= CNT_W'(`FB_TRCD - 2);
                end
                ST_TRCD: if (cnt == '0) begin
                    state <= ST_DATA;
                    cnt   <= burst_last;
                end
                ST_DATA: begin
                    // column 0, A10 low so no auto precharge
                    if (cnt == burst_last) begin
                        cmd_q        <= rw_q ? CMD_READ : CMD_WRITE;
                        o_sdram_addr <= '0;
                    end
                    if (data_beat && rw_q) begin
                        burst_rd <= 1'b1;
                    end
                    // missing write word is masked off
                    if (data_beat && !rw_q) begin
                        o_sdram_dq_oe <= 1'b1;
                        o_sdram_dqm   <= {2{!i_wr_valid}};
                    end
                    if (cnt == '0) begin
                        cmd_q        <= CMD_PRECHARGE;
                        o_sdram_addr <= PRE_ALL;
                        state        <= ST_TRP;
                        cnt          <= CNT_W'(`FB_TRP - 1);
                    end
                end
                ST_TRP: if (cnt == '0) begin
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // write data rides with the pop
    always_ff @(posedge s_sdram_clk) begin
        if (o_wr_pop) begin
            o_sdram_dq <= i_wr_data;
        end
    end

    // captured read word, sof only on the first of a replay
    always_ff @(posedge s_sdram_clk) begin
        if (rd_pipe[CL-1]) begin
            o_rd_word.pix <= i_sdram_dq;
            o_rd_word.sof <= sof_pend;
        end
    end

endmodule

//--- rtl/page_arbiter.sv
`timescale 1ns/10ps
`include "frame_buf_config.svh"

module page_arbiter #(
    parameter int  FIFO_DEPTH = 2 * `FB_PAGE_LEN,
    localparam int CNT_W      = $clog2(FIFO_DEPTH) + 1
) (
    input  logic             s_sdram_clk,
    input  logic             s_sdram_rst,
    input  logic             i_new_frame,
    input  logic [CNT_W-1:0] i_wr_count,
    input  logic [CNT_W-1:0] i_rd_count,
    output logic             o_rd_flush,
    sdram_req_if.arb         req
);
    // page counters must reach FB_FRAME_PAGES itself
    localparam int PAGE_W = $clog2(`FB_FRAME_PAGES + 1);
    localparam int ROW_W  = `FB_ROW_W;

    logic              busy;
    logic              frame_pend;
    logic [PAGE_W-1:0] write_row;
    logic [PAGE_W-1:0] read_row;
    logic [PAGE_W-1:0] pages_written;
    logic              go_restart;
    logic              go_read;
    logic              go_write;

    // replay only once something has been stored
    assign go_restart = frame_pend && (pages_written != '0);
    // read fifo must take a whole page, sdram data can't be stalled
    assign go_read    = (read_row < pages_written) &&
                        (i_rd_count <= CNT_W'(FIFO_DEPTH - `FB_PAGE_LEN));
    // full page waiting in the write fifo
    assign go_write   = (i_wr_count >= CNT_W'(`FB_PAGE_LEN));

    always_ff @(posedge s_sdram_clk) begin
        if (s_sdram_rst) begin
            busy          <= 1'b0;
            frame_pend    <= 1'b0;
            write_row     <= '0;
            read_row      <= '0;
            pages_written <= '0;
            o_rd_flush    <= 1'b0;
            req.rw_en     <= 1'b0;
            req.rw        <= 1'b0;
            req.row       <= '0;
            req.sof       <= 1'b0;
        end else begin
            // strobes last one cycle
            req.rw_en  <= 1'b0;
            o_rd_flush <= 1'b0;
            // hold the frame pulse until it can be served
            if (i_new_frame) begin
                frame_pend <= 1'b1;
            end
            if (!busy) begin
                if (req.ready && (go_restart || go_read || go_write)) begin
                    busy      <= 1'b1;
                    req.rw_en <= 1'b1;
                    req.rw    <= go_restart || go_read;
                    req.sof   <= go_restart;
                    // priority restart, then read, then write
                    if (go_restart) begin
                        frame_pend <= i_new_frame;
                        read_row   <= '0;
                        req.row    <= '0;
                        o_rd_flush <= 1'b1;
                    end else if (go_read) begin
                        req.row <= ROW_W'(read_row);
                    end else begin
                        req.row <= ROW_W'(write_row);
                    end
                end
            end else if (req.ready && !req.rw_en) begin
                // engine back to idle, burst finished
                busy <= 1'b0;
                if (req.rw) begin
                    read_row <= read_row + 1'b1;
                end else begin
                    write_row <= (write_row == PAGE_W'(`FB_FRAME_PAGES - 1)) ?
                                 '0 : write_row + 1'b1;
                    if (pages_written != PAGE_W'(`FB_FRAME_PAGES)) begin
                        pages_written <= pages_written + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16,
    localparam int AW        = $clog2(DEPTH),
    localparam int CW        = AW + 1
) (
    input  logic     s_sdram_clk,
    input  logic     s_sdram_rst,
    input  logic     i_flush,
    input  logic     i_wr_valid,
    input  payload_t i_wr_data,
    output logic     o_wr_ready,
    output logic     o_rd_valid,
    output payload_t o_rd_data,
    input  logic     i_rd_ready,
    output logic [CW-1:0] o_count
);
    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          push;
    logic          pop;

    assign o_wr_ready = (o_count != CW'(DEPTH));
    assign o_rd_valid = (o_count != '0);
    // head word shows as soon as count is nonzero
    assign o_rd_data  = mem[rd_ptr];

    assign push = i_wr_valid && o_wr_ready;
    assign pop  = o_rd_valid && i_rd_ready;

    always_ff @(posedge s_sdram_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    always_ff @(posedge s_sdram_clk) begin
        if (s_sdram_rst || i_flush) begin
            // flush drops everything in one cycle
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (push && !pop) begin
                o_count <= o_count + 1'b1;
            end else if (pop && !push) begin
                o_count <= o_count - 1'b1;
            end
        end
    end

endmodule

//--- rtl/sdram_req_if.sv
`timescale 1ns/10ps
`include "frame_buf_config.svh"

interface sdram_req_if;

    // one-cycle request strobe
    logic                 rw_en;
    // 1 read, 0 write
    logic                 rw;
    // page row to open
    logic [`FB_ROW_W-1:0] row;
    // read is the start of a frame replay
    logic                 sof;
    // engine idle, next request may go
    logic                 ready;

    modport arb (output rw_en, output rw, output row, output sof, input ready);

    modport eng (input rw_en, input rw, input row, input sof, output ready);

endinterface

//--- rtl/frame_buf_pkg.sv
`include "frame_buf_config.svh"

package frame_buf_pkg;

    // one stored pixel
    typedef logic [`FB_DATA_W-1:0] pixel_t;

    // replayed word, sof flags first word of a frame
    typedef struct packed {
        logic   sof;
        pixel_t pix;
    } rd_word_t;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_e;

endpackage

//--- rtl/frame_buf_config.svh
`ifndef FRAME_BUF_CONFIG_SVH
`define FRAME_BUF_CONFIG_SVH

// pixel and payload width
`define FB_DATA_W 16
// words per page burst, also the sdram burst length
`define FB_PAGE_LEN 8
// pages making up one frame
`define FB_FRAME_PAGES 4

// sdram geometry
`define FB_ROW_W 13
`define FB_BANK_W 2

// sdram timing in s_sdram_clk cycles
`define FB_CAS_LAT 2
`define FB_TRCD 2
`define FB_TRP 2
`define FB_INIT_WAIT 20

`endif
